// ==== dv/lsu_tb.sv ====
// --------------------
// random testbench for the load/store unit
// models memory and checks requests and commits
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

    localparam int num_instr      = 300;
    localparam int timeout_cycles = num_instr * mload_beats * 20;
    localparam int drain_cycles   = 10;

    logic      clk;
    logic      reset;
    logic      exec_valid;
    logic      exec_ready;
    lsu_exec_t exec;
    logic      mem_req_valid;
    logic      mem_req_ready;
    mem_req_t  mem_req;
    logic      mem_rsp_valid;
    logic      mem_rsp_ready;
    mem_rsp_t  mem_rsp;
    logic      commit_valid;
    logic      commit_ready;
    commit_t   commit;

    logic [31:0] mem_words [256];
    mem_rsp_t    rsp_q [$];
    int          rsp_due [$];
    commit_t     exp_ld_q [$];
    commit_t     exp_st_q [$];

    lsu_top dut0 (
        .clk           (clk),
        .reset         (reset),
        .exec_valid    (exec_valid),
        .exec_ready    (exec_ready),
        .exec          (exec),
        .mem_req_valid (mem_req_valid),
        .mem_req_ready (mem_req_ready),
        .mem_req       (mem_req),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp       (mem_rsp),
        .commit_valid  (commit_valid),
        .commit_ready  (commit_ready),
        .commit        (commit)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic halt_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_mem_req(string name, mem_req_t expected, mem_req_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
            halt_with_failure();
        end
    endtask

    task automatic check_commit(string name, commit_t expected, commit_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s: expected %h actual %h", name, expected, actual);
            halt_with_failure();
        end
    endtask

    function automatic lsu_exec_t random_instr(int n);
        lsu_exec_t  e;
        logic [1:0] off;
        e.op    = lsu_op_e'($urandom_range(0, 9));
        e.wid   = 2'($urandom);
        e.pc    = 32'h1000 + 32'(4 * n);
        e.tmask = 4'($urandom);
        e.rd    = 5'($urandom);
        case (e.op)
            op_lb, op_lbu, op_sb: off = 2'($urandom);
            op_lh, op_lhu, op_sh: off = {1'($urandom), 1'b0};
            default: off = 2'b00;
        endcase
        e.imm = 32'($urandom_range(0, 15) * 4) + 32'(off);
        // small address window so loads see earlier stores
        for (int i = 0; i < num_lanes; i++) begin
            e.rs1_data[i] = 32'($urandom_range(0, 255) * 4);
            if (e.op == op_mload) begin
                e.rs2_data[i] = 32'($urandom_range(0, 255) * 4);
            end else begin
                e.rs2_data[i] = $urandom;
            end
        end
        return e;
    endfunction

    function automatic mem_req_t expect_req(lsu_exec_t e, int b);
        mem_req_t    r;
        logic [31:0] a;
        logic [1:0]  off;
        logic        ml;
        ml          = (e.op == op_mload);
        r.rw        = e.op inside {op_sb, op_sh, op_sw, op_mstore};
        r.mask      = e.tmask;
        r.tag.wid   = e.wid;
        r.tag.pc    = e.pc;
        r.tag.tmask = e.tmask;
        r.tag.op    = e.op;
        r.tag.rd    = ml ? e.rd + 5'(b) : e.rd;
        r.tag.eop   = !ml || (b == mload_beats - 1);
        for (int i = 0; i < num_lanes; i++) begin
            if (ml && b < 2) begin
                a = e.rs1_data[i] + 32'(4 * ((i / 2) * 2 + b));
            end else if (ml) begin
                a = e.rs2_data[i] + 32'(4 * (i % 2 + (b == 3 ? 2 : 0)));
            end else if (e.op == op_mstore) begin
                a = e.rs1_data[i] + 32'(4 * i);
            end else begin
                a = e.rs1_data[i] + e.imm;
            end
            off            = a[1:0];
            r.addr[i]      = a[31:2];
            r.tag.align[i] = off;
            r.data[i]      = e.rs2_data[i] << (8 * off);
            case (e.op)
                op_lb, op_lbu, op_sb: r.byteen[i] = 4'b0001 << off;
                op_lh, op_lhu, op_sh: r.byteen[i] = 4'b0011 << (2 * off[1]);
                default: r.byteen[i] = 4'b1111;
            endcase
        end
        return r;
    endfunction

    function automatic logic [31:0] load_value(lsu_op_e op, logic [31:0] word, logic [1:0] off);
        logic [31:0] by;
        logic [31:0] hw;
        by = word >> (8 * off);
        hw = word >> (16 * off[1]);
        case (op)
            op_lb:   return {{24{by[7]}}, by[7:0]};
            op_lbu:  return {24'h0, by[7:0]};
            op_lh:   return {{16{hw[15]}}, hw[15:0]};
            op_lhu:  return {16'h0, hw[15:0]};
            default: return word;
        endcase
    endfunction

    initial begin
        lsu_exec_t cur;
        mem_req_t  exp_req;
        mem_rsp_t  rsp;
        commit_t   exp_commit;
        commit_t   head;
        int        issued;
        int        beat_idx;
        int        cycle;
        int        drain;
        logic      exec_fire;
        logic      req_fire;
        logic      is_ml;
        logic      is_st;
        logic      done;

        void'($urandom(32'hc342db8d));
        reset         = 1'b1;
        exec_valid    = 1'b0;
        exec          = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        commit_ready  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem_words[i] = {8'(i) ^ 8'h5a, ~8'(i), 8'(i) + 8'h33, 8'(i)};
        end
        beat_idx = 0;
        cycle    = 0;
        drain    = 0;

        repeat (10) @(posedge clk);
        reset      <= 1'b0;
        cur         = random_instr(0);
        issued      = 1;
        exec       <= cur;
        exec_valid <= 1'b1;

        while (drain < drain_cycles) begin
            @(posedge clk);
            cycle++;
            if (cycle > timeout_cycles) begin
                $display("timeout: not every instruction committed after %0d cycles", cycle);
                halt_with_failure();
            end
            exec_fire = exec_valid && exec_ready;
            req_fire  = mem_req_valid && mem_req_ready;
            is_ml     = (cur.op == op_mload);
            is_st     = cur.op inside {op_sb, op_sh, op_sw, op_mstore};

            if (mem_req_valid !== exec_valid) begin
                $display("memory request valid does not follow execute valid");
                halt_with_failure();
            end
            if (exec_fire && !req_fire) begin
                $display("instruction was consumed without its memory request");
                halt_with_failure();
            end
            if (req_fire && !exec_fire && !is_ml && !is_st) begin
                $display("load request was sent while the load was not consumed");
                halt_with_failure();
            end
            if (exec_fire && is_ml && beat_idx != mload_beats - 1) begin
                $display("matrix load was consumed on beat %0d instead of the last", beat_idx);
                halt_with_failure();
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                void'(rsp_q.pop_front());
                void'(rsp_due.pop_front());
            end

            if (req_fire) begin
                exp_req = expect_req(cur, beat_idx);
                check_mem_req($sformatf("request of instruction %0d", issued), exp_req, mem_req);
                if (mem_req.rw) begin
                    for (int i = 0; i < num_lanes; i++) begin
                        for (int j = 0; j < word_bytes; j++) begin
                            if (mem_req.mask[i] && mem_req.byteen[i][j]) begin
                                mem_words[mem_req.addr[i][7:0]][8 * j +: 8] =
                                    mem_req.data[i][8 * j +: 8];
                            end
                        end
                    end
                end else begin
                    rsp.mask         = mem_req.mask;
                    rsp.tag          = mem_req.tag;
                    exp_commit.wid   = cur.wid;
                    exp_commit.pc    = cur.pc;
                    exp_commit.tmask = cur.tmask;
                    exp_commit.rd    = exp_req.tag.rd;
                    exp_commit.wb    = 1'b1;
                    exp_commit.eop   = exp_req.tag.eop;
                    for (int i = 0; i < num_lanes; i++) begin
                        rsp.data[i]        = mem_words[mem_req.addr[i][7:0]];
                        exp_commit.data[i] = load_value(cur.op, rsp.data[i],
                                                        exp_req.tag.align[i]);
                    end
                    rsp_q.push_back(rsp);
                    rsp_due.push_back(cycle + $urandom_range(0, 3));
                    exp_ld_q.push_back(exp_commit);
                end
                if (is_ml) begin
                    beat_idx = (beat_idx + 1) % mload_beats;
                end
            end

            if (exec_fire && is_st) begin
                exp_commit       = '0;
                exp_commit.wid   = cur.wid;
                exp_commit.pc    = cur.pc;
                exp_commit.tmask = cur.tmask;
                exp_commit.eop   = 1'b1;
                exp_st_q.push_back(exp_commit);
            end

            // loads and stores each keep issue order
            if (commit_valid && commit_ready) begin
                if (commit.wb && exp_ld_q.size() == 0) begin
                    $display("load commit arrived with no load outstanding");
                    halt_with_failure();
                end else if (!commit.wb && exp_st_q.size() == 0) begin
                    $display("store commit arrived with no store outstanding");
                    halt_with_failure();
                end else if (commit.wb) begin
                    head = exp_ld_q.pop_front();
                    check_commit("load commit", head, commit);
                end else begin
                    head = exp_st_q.pop_front();
                    check_commit("store commit", head, commit);
                end
            end

            done = (issued == num_instr) && !exec_valid && (exp_ld_q.size() == 0)
                && (exp_st_q.size() == 0) && (rsp_q.size() == 0);
            if (done) begin
                drain++;
            end

            mem_req_ready <= ($urandom_range(0, 4) != 0);
            commit_ready  <= ($urandom_range(0, 3) != 0);
            if (rsp_q.size() > 0 && rsp_due[0] <= cycle) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp       <= rsp_q[0];
            end else begin
                mem_rsp_valid <= 1'b0;
            end
            if (exec_fire) begin
                if (issued < num_instr) begin
                    cur   = random_instr(issued);
                    issued++;
                    exec <= cur;
                end else begin
                    exec_valid <= 1'b0;
                end
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
source/lsu_pkg.sv
source/lsu_elastic_buf.sv
source/lsu_mload_seq.sv
source/lsu_req_format.sv
source/lsu_rsp_format.sv
source/lsu_commit_arb.sv
source/lsu_top.sv
dv/lsu_tb.sv

// ==== source/lsu_commit_arb.sv ====
// --------------------
// store and load commit buffers merged round-robin
// onto one registered commit port
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_commit_arb import lsu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    st_valid,
    output logic    st_ready,
    input  commit_t st_commit,
    input  logic    ld_valid,
    output logic    ld_ready,
    input  commit_t ld_commit,
    output logic    commit_valid,
    input  logic    commit_ready,
    output commit_t commit
);

    logic    st_buf_valid;
    logic    st_buf_ready;
    commit_t st_buf_data;
    logic    ld_buf_valid;
    logic    ld_buf_ready;
    commit_t ld_buf_data;
    logic    favor_ld;
    logic    out_load;
    logic    grant_ld;
    logic    grant_st;

    lsu_elastic_buf st_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (st_valid),
        .in_ready  (st_ready),
        .in_data   (st_commit),
        .out_valid (st_buf_valid),
        .out_ready (st_buf_ready),
        .out_data  (st_buf_data)
    );

    lsu_elastic_buf ld_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ld_valid),
        .in_ready  (ld_ready),
        .in_data   (ld_commit),
        .out_valid (ld_buf_valid),
        .out_ready (ld_buf_ready),
        .out_data  (ld_buf_data)
    );

    // output slot free or draining this cycle
    assign out_load = !commit_valid || commit_ready;
    assign grant_ld = ld_buf_valid && (favor_ld || !st_buf_valid);
    assign grant_st = st_buf_valid && !grant_ld;

    assign ld_buf_ready = out_load && grant_ld;
    assign st_buf_ready = out_load && grant_st;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            favor_ld     <= 1'b1;
        end else if (out_load) begin
            commit_valid <= grant_ld || grant_st;
            if (grant_ld) begin
                favor_ld <= 1'b0;
            end else if (grant_st) begin
                favor_ld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (out_load && (grant_ld || grant_st)) begin
            commit <= grant_ld ? ld_buf_data : st_buf_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/lsu_elastic_buf.sv ====
// --------------------
// two-entry FIFO for commit records
// registered output, one record per cycle
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_elastic_buf import lsu_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    in_valid,
    output logic    in_ready,
    input  commit_t in_data,
    output logic    out_valid,
    input  logic    out_ready,
    output commit_t out_data
);

    commit_t    entries [2];
    logic [1:0] count;
    logic       wr_ptr;
    logic       rd_ptr;
    logic       push;
    logic       pop;

    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entries[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            count  <= '0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr ^ push;
            rd_ptr <= rd_ptr ^ pop;
            count  <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/lsu_mload_seq.sv ====
// --------------------
// beat sequencer for matrix loads
// also decides when the execute port accepts
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_mload_seq import lsu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        exec_valid,
    input  lsu_op_e     exec_op,
    input  logic        is_store,
    input  logic        mem_req_ready,
    input  logic        st_ready,
    output mload_beat_t beat,
    output logic        exec_ready
);

    logic                 mode_q;
    logic [beat_bits-1:0] count_q;
    logic                 is_mload;
    logic                 lsu_ready;
    logic                 last_beat;

    assign is_mload  = exec_valid && (exec_op == op_mload);
    // stores also need room in the store commit buffer
    assign lsu_ready = mem_req_ready && (!is_store || st_ready);
    assign last_beat = (count_q == beat_bits'(mload_beats - 1));

    // instruction is held until beat 3 goes out
    assign exec_ready = lsu_ready && ((exec_op != op_mload) || last_beat);

    assign beat.active = is_mload || mode_q;
    assign beat.index  = count_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            mode_q  <= 1'b0;
            count_q <= '0;
        end else if (is_mload && lsu_ready) begin
            if (last_beat) begin
                mode_q  <= 1'b0;
                count_q <= '0;
            end else begin
                mode_q  <= 1'b1;
                count_q <= count_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
// --------------------
// shared widths, op encoding and records of the load/store unit
// imported by every RTL module and the testbench
// --------------------
`default_nettype none

package lsu_pkg;

    localparam int xlen        = 32;
    localparam int num_lanes   = 4;
    localparam int word_bytes  = 4;
    localparam int align_bits  = 2;
    localparam int nw_bits     = 2;
    localparam int nr_bits     = 5;
    localparam int mload_beats = 4;
    localparam int beat_bits   = 2;

    typedef enum logic [3:0] {
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw,
        op_mload,
        op_mstore
    } lsu_op_e;

    typedef struct packed {
        logic [nw_bits-1:0]                wid;
        logic [xlen-1:0]                   pc;
        logic [num_lanes-1:0]              tmask;
        lsu_op_e                           op;
        logic [nr_bits-1:0]                rd;
        logic [xlen-1:0]                   imm;
        logic [num_lanes-1:0][xlen-1:0]    rs1_data;
        logic [num_lanes-1:0][xlen-1:0]    rs2_data;
    } lsu_exec_t;

    typedef struct packed {
        logic                 active;
        logic [beat_bits-1:0] index;
    } mload_beat_t;

    // returned unchanged by memory
    typedef struct packed {
        logic [nw_bits-1:0]                   wid;
        logic [xlen-1:0]                      pc;
        logic [num_lanes-1:0]                 tmask;
        logic [nr_bits-1:0]                   rd;
        lsu_op_e                              op;
        logic [num_lanes-1:0][align_bits-1:0] align;
        logic                                 eop;
    } mem_tag_t;

    typedef struct packed {
        logic                                       rw;
        logic [num_lanes-1:0]                       mask;
        logic [num_lanes-1:0][xlen-align_bits-1:0]  addr;
        logic [num_lanes-1:0][word_bytes-1:0]       byteen;
        logic [num_lanes-1:0][xlen-1:0]             data;
        mem_tag_t                                   tag;
    } mem_req_t;

    typedef struct packed {
        logic [num_lanes-1:0]           mask;
        logic [num_lanes-1:0][xlen-1:0] data;
        mem_tag_t                       tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [nw_bits-1:0]             wid;
        logic [xlen-1:0]                pc;
        logic [num_lanes-1:0]           tmask;
        logic [nr_bits-1:0]             rd;
        logic                           wb;
        logic [num_lanes-1:0][xlen-1:0] data;
        logic                           eop;
    } commit_t;

endpackage

`default_nettype wire

// ==== source/lsu_req_format.sv ====
// --------------------
// builds the memory request from the execute record
// lane addresses, byte enables, shifted store data and tag
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_req_format import lsu_pkg::*; (
    input  logic        exec_valid,
    input  lsu_exec_t   exec,
    input  mload_beat_t beat,
    input  logic        mem_req_ready,
    output logic        mem_req_valid,
    output mem_req_t    mem_req,
    output logic        is_store,
    output logic        st_valid,
    output commit_t     st_commit
);

    logic [num_lanes-1:0][xlen-1:0]       lane_addr;
    logic [num_lanes-1:0][align_bits-1:0] lane_align;
    logic                                 is_mstore;
    mem_tag_t                             tag;

    assign is_mstore     = (exec.op == op_mstore);
    assign is_store      = exec.op inside {op_sb, op_sh, op_sw, op_mstore};
    assign mem_req_valid = exec_valid;
    assign st_valid      = mem_req_valid && mem_req_ready && is_store;

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            if (beat.active) begin
                // first two beats walk rs1 pairwise, last two walk rs2
                if (!beat.index[1]) begin
                    lane_addr[i] = exec.rs1_data[i]
                        + xlen'(word_bytes) * (xlen'(2 * (i / 2)) + xlen'(beat.index));
                end else begin
                    lane_addr[i] = exec.rs2_data[i]
                        + xlen'(word_bytes) * (xlen'(i % 2) + xlen'({beat.index[0], 1'b0}));
                end
            end else if (is_mstore) begin
                lane_addr[i] = exec.rs1_data[i] + xlen'(word_bytes * i);
            end else begin
                lane_addr[i] = exec.rs1_data[i] + exec.imm;
            end
            lane_align[i] = lane_addr[i][align_bits-1:0];
        end
    end

    always_comb begin
        tag.wid   = exec.wid;
        tag.pc    = exec.pc;
        tag.tmask = exec.tmask;
        tag.rd    = exec.rd + (beat.active ? nr_bits'(beat.index) : '0);
        tag.op    = exec.op;
        tag.align = lane_align;
        tag.eop   = !beat.active || (beat.index == beat_bits'(mload_beats - 1));
    end

    always_comb begin
        mem_req.rw   = is_store;
        mem_req.mask = exec.tmask;
        mem_req.tag  = tag;
        for (int i = 0; i < num_lanes; i++) begin
            mem_req.addr[i]   = lane_addr[i][xlen-1:align_bits];
            mem_req.byteen[i] = '0;
            case (exec.op)
                op_lb, op_lbu, op_sb: begin
                    mem_req.byteen[i][lane_align[i]] = 1'b1;
                end
                op_lh, op_lhu, op_sh: begin
                    mem_req.byteen[i][{lane_align[i][1], 1'b0}] = 1'b1;
                    mem_req.byteen[i][{lane_align[i][1], 1'b1}] = 1'b1;
                end
                default: mem_req.byteen[i] = '1;
            endcase
            mem_req.data[i] = exec.rs2_data[i] << {lane_align[i], 3'b000};
        end
    end

    // stores write nothing back
    always_comb begin
        st_commit.wid   = exec.wid;
        st_commit.pc    = exec.pc;
        st_commit.tmask = exec.tmask;
        st_commit.rd    = '0;
        st_commit.wb    = 1'b0;
        st_commit.data  = '0;
        st_commit.eop   = 1'b1;
    end

endmodule

`default_nettype wire

// ==== source/lsu_rsp_format.sv ====
// --------------------
// turns a memory response into a load commit record
// lane extraction and sign or zero extension
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_rsp_format import lsu_pkg::*; (
    input  logic     mem_rsp_valid,
    input  mem_rsp_t mem_rsp,
    output logic     ld_valid,
    output commit_t  ld_commit
);

    logic [num_lanes-1:0][xlen-1:0] lane_data;

    always_comb begin
        logic [15:0] half;
        logic [7:0]  byte_val;
        for (int i = 0; i < num_lanes; i++) begin
            half     = mem_rsp.tag.align[i][1] ? mem_rsp.data[i][31:16] : mem_rsp.data[i][15:0];
            byte_val = mem_rsp.tag.align[i][0] ? half[15:8] : half[7:0];
            case (mem_rsp.tag.op)
                op_lb:   lane_data[i] = xlen'(signed'(byte_val));
                op_lh:   lane_data[i] = xlen'(signed'(half));
                op_lbu:  lane_data[i] = xlen'(byte_val);
                op_lhu:  lane_data[i] = xlen'(half);
                // word and matrix loads
                default: lane_data[i] = mem_rsp.data[i];
            endcase
        end
    end

    assign ld_valid = mem_rsp_valid;

    always_comb begin
        ld_commit.wid   = mem_rsp.tag.wid;
        ld_commit.pc    = mem_rsp.tag.pc;
        ld_commit.tmask = mem_rsp.mask;
        ld_commit.rd    = mem_rsp.tag.rd;
        ld_commit.wb    = 1'b1;
        ld_commit.data  = lane_data;
        ld_commit.eop   = mem_rsp.tag.eop;
    end

endmodule

`default_nettype wire

// ==== source/lsu_top.sv ====
// --------------------
// four-lane load/store unit top level
// execute, memory and commit valid/ready ports
// --------------------
`timescale 1ns/1ps
`default_nettype none

module lsu_top import lsu_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      exec_valid,
    output logic      exec_ready,
    input  lsu_exec_t exec,
    output logic      mem_req_valid,
    input  logic      mem_req_ready,
    output mem_req_t  mem_req,
    input  logic      mem_rsp_valid,
    output logic      mem_rsp_ready,
    input  mem_rsp_t  mem_rsp,
    output logic      commit_valid,
    input  logic      commit_ready,
    output commit_t   commit
);

    mload_beat_t beat;
    logic        is_store;
    logic        st_valid;
    logic        st_ready;
    commit_t     st_commit;
    logic        ld_valid;
    commit_t     ld_commit;

    lsu_mload_seq mload_seq (
        .clk           (clk),
        .reset         (reset),
        .exec_valid    (exec_valid),
        .exec_op       (exec.op),
        .is_store      (is_store),
        .mem_req_ready (mem_req_ready),
        .st_ready      (st_ready),
        .beat          (beat),
        .exec_ready    (exec_ready)
    );

    lsu_req_format req_format (
        .exec_valid    (exec_valid),
        .exec          (exec),
        .beat          (beat),
        .mem_req_ready (mem_req_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .is_store      (is_store),
        .st_valid      (st_valid),
        .st_commit     (st_commit)
    );

    lsu_rsp_format rsp_format (
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .ld_valid      (ld_valid),
        .ld_commit     (ld_commit)
    );

    // load buffer ready is the response ready
    lsu_commit_arb commit_arb (
        .clk          (clk),
        .reset        (reset),
        .st_valid     (st_valid),
        .st_ready     (st_ready),
        .st_commit    (st_commit),
        .ld_valid     (ld_valid),
        .ld_ready     (mem_rsp_ready),
        .ld_commit    (ld_commit),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit)
    );

endmodule

`default_nettype wire
